//--- imu_bridge.f
hdl/imu_bridge_pkg.sv
hdl/imu_link_if.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/command_accumulator.sv
hdl/frame_timer.sv
hdl/spi_imu_reader.sv
hdl/bridge_sequencer.sv
hdl/imu_bridge.sv
dv/tb_clock.sv
dv/imu_bridge_tb.sv

//--- dv/imu_bridge_tb.sv
`default_nettype none

module imu_bridge_tb;

  localparam int                    CPB         = 8;
  localparam int                    HALF_SCLK   = 2;
  localparam int                    TIMEOUT     = 400;
  localparam imu_bridge_pkg::word_t PAD         = 16'hA5C3;
  localparam int                    DRIVE_DLY   = 2;
  localparam byte                   YAW_ID      = 8'd2;
  localparam logic [15:0]           ACK_ID      = 16'd1;
  localparam int                    SEND_CYC    = 4 * 10 * CPB;         // Up to four bytes in
  localparam int                    SPI_CYC     = 48 * HALF_SCLK + 4;
  localparam int                    RSP_CYC     = 4 * (10 * CPB + 4);   // Four bytes out
  localparam int                    N_FRAMES    = 9;
  localparam int                    CYCLE_LIMIT = 16 + N_FRAMES *
                                                  (SEND_CYC + SPI_CYC + RSP_CYC + TIMEOUT);

  wire                   clk;
  wire                   reset;
  logic                  rx_line;
  wire                   tx_line;
  wire                   sclk;
  wire                   mosi;
  logic                  miso;
  wire                   cs_n;
  logic [31:0]           lfsr;
  imu_bridge_pkg::byte_t rsp_q[$];       // Bytes seen on the response line
  imu_bridge_pkg::byte_t spi_cmd;        // Last command byte from the DUT
  imu_bridge_pkg::word_t spi_value;      // Last value returned by the IMU model
  int                    spi_count;
  logic                  enc_mode;       // Expected encryption mode
  int                    cycle_count = 0;

  tb_clock #(.PERIOD(20), .RESET_CYCLES(8)) i_clock (.o_clk(clk), .o_reset(reset));

  imu_bridge #(
    .CLKS_PER_BIT       (CPB),
    .CLKS_PER_HALF_SCLK (HALF_SCLK),
    .FRAME_TIMEOUT      (TIMEOUT),
    .OTP_PAD            (PAD)
  ) i_dut (
    .clk        (clk),
    .reset      (reset),
    .i_uart_rx  (rx_line),
    .o_uart_tx  (tx_line),
    .o_spi_sclk (sclk),
    .o_spi_mosi (mosi),
    .i_spi_miso (miso),
    .o_spi_cs_n (cs_n)
  );

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_word(output imu_bridge_pkg::word_t w);
    w = '0;
    for (int i = 0; i < 16; i++) begin
      w    = {w[14:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);  // One step per bit
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic send_byte(input imu_bridge_pkg::byte_t b);
    rx_line = 1'b0;  // Start bit
    wait_cycles(CPB);
    for (int i = 0; i < 8; i++) begin
      rx_line = b[i];
      wait_cycles(CPB);
    end
    rx_line = 1'b1;
    wait_cycles(CPB);
  endtask

  task automatic send_command(input imu_bridge_pkg::word_t w);
    send_byte(w[7:0]);
    send_byte(w[15:8]);
    send_byte(imu_bridge_pkg::FRAME_TERM);
  endtask

  task automatic wait_response(output logic [31:0] rsp);
    int waited;
    waited = 0;
    while (rsp_q.size() < 4 && waited < SEND_CYC + SPI_CYC + RSP_CYC) begin
      wait_cycles(1);
      waited++;
    end
    assert (rsp_q.size() == 4) else report_error("No complete response arrived in time");
    rsp = {rsp_q[3], rsp_q[2], rsp_q[1], rsp_q[0]};  // ID went out first
    rsp_q.delete();
  endtask

  task automatic check_response(input logic [31:0] got, input logic [31:0] expected);
    for (int i = 0; i < 4; i++) begin
      assert (got[8*i +: 8] == expected[8*i +: 8])
        else report_error($sformatf("Mismatch at time %0t: response byte %0d is %h, expected %h",
                                    $time, i, got[8*i +: 8], expected[8*i +: 8]));
    end
  endtask

  task automatic run_read(input imu_bridge_pkg::word_t cmd);
    int          count_before;
    logic [31:0] rsp;
    logic [31:0] expected;
    count_before = spi_count;
    send_command(cmd ^ (enc_mode ? PAD : 16'h0000));
    wait_response(rsp);
    assert (spi_count == count_before + 1) else report_error("Read command gave no SPI transfer");
    assert (spi_cmd == {5'b0, cmd[2:0]})
      else report_error($sformatf("Mismatch at time %0t: SPI command byte %h, expected %h",
                                  $time, spi_cmd, {5'b0, cmd[2:0]}));
    expected = {8'h00, spi_value[15:8], spi_value[7:0], YAW_ID};  // Status byte is zero on success
    if (enc_mode) begin
      expected = expected ^ {PAD, PAD};
    end
    check_response(rsp, expected);
  endtask

  task automatic run_mode(input imu_bridge_pkg::word_t cmd, input logic new_mode);
    int          count_before;
    logic [31:0] rsp;
    logic [31:0] expected;
    count_before = spi_count;
    send_command(cmd ^ (enc_mode ? PAD : 16'h0000));
    enc_mode = new_mode;  // Ack already uses the new mode
    wait_response(rsp);
    assert (spi_count == count_before) else report_error("Mode command started an SPI transfer");
    expected = {16'h0000, ACK_ID};
    if (enc_mode) begin
      expected = expected ^ {PAD, PAD};
    end
    check_response(rsp, expected);
  endtask

  task automatic expect_silence(input int n);
    int count_before;
    count_before = spi_count;
    wait_cycles(n);
    assert (rsp_q.size() == 0 && spi_count == count_before)
      else report_error("Discarded frame still produced activity");
  endtask

  // UART monitor sampling on the falling clock edge
  initial begin : uart_monitor
    imu_bridge_pkg::byte_t b;
    forever begin
      @(negedge clk);
      if (tx_line === 1'b0) begin
        repeat (CPB / 2) @(negedge clk);  // Middle of the start bit
        for (int i = 0; i < 8; i++) begin
          repeat (CPB) @(negedge clk);
          b[i] = tx_line;
        end
        repeat (CPB) @(negedge clk);
        assert (tx_line === 1'b1) else report_error("Response byte has no stop bit");
        rsp_q.push_back(b);
      end
    end
  end

  // IMU model on SPI mode 0
  initial begin : spi_model
    logic [23:0]           out;
    imu_bridge_pkg::byte_t cap;
    miso = 1'b0;
    forever begin
      @(negedge cs_n);
      #DRIVE_DLY;
      draw_word(spi_value);
      out  = {8'h00, spi_value[7:0], spi_value[15:8]};  // Low byte right after the command
      miso = out[23];
      for (int i = 0; i < 24; i++) begin
        @(posedge sclk);
        if (i < 8) begin
          cap = {cap[6:0], mosi};
        end
        @(negedge sclk);
        #DRIVE_DLY;
        out  = out << 1;
        miso = out[23];
      end
      spi_cmd = cap;
      spi_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT) begin
      report_error($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  initial begin
    rx_line   = 1'b1;
    lfsr      = 32'h164a_0dde;
    enc_mode  = 1'b0;
    spi_count = 0;
    @(negedge reset);
    wait_cycles(1);
    assert (tx_line === 1'b1 && cs_n === 1'b1 && sclk === 1'b0)
      else report_error($sformatf("Mismatch at time %0t: idle outputs tx=%b cs_n=%b sclk=%b",
                                  $time, tx_line, cs_n, sclk));
    run_read(16'h0013);
    run_mode(16'h0002, 1'b1);
    run_read(16'h0105);         // Sent encrypted
    run_mode(16'h0001, 1'b0);
    run_read(16'h0026);
    send_byte(8'h14);           // Three bytes before the terminator
    send_byte(8'h00);
    send_byte(8'h31);
    send_byte(imu_bridge_pkg::FRAME_TERM);
    expect_silence(SPI_CYC + RSP_CYC);
    run_read(16'h0007);
    send_byte(8'h23);           // Stale single byte
    expect_silence(TIMEOUT + 40);
    run_read(16'h0044);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset = 1'b0;  // Released just after an edge
  end

endmodule

`default_nettype wire

//--- hdl/imu_bridge.sv
`default_nettype none

module imu_bridge #(
  parameter int                    CLKS_PER_BIT       = 5208,  // 9600 baud at 50 MHz
  parameter int                    CLKS_PER_HALF_SCLK = 2,
  parameter int                    FRAME_TIMEOUT      = 4000000,
  parameter imu_bridge_pkg::word_t OTP_PAD            = 16'hA5C3
) (
  input  wire  clk,
  input  wire  reset,
  input  wire  i_uart_rx,
  output logic o_uart_tx,
  output logic o_spi_sclk,
  output logic o_spi_mosi,
  input  wire  i_spi_miso,
  output logic o_spi_cs_n
);

  imu_bridge_pkg::byte_t rx_byte;
  logic                  rx_valid;
  imu_bridge_pkg::word_t cmd_word;
  logic                  cmd_first;
  logic                  cmd_done;
  logic                  cmd_error;
  logic                  frame_expired;
  logic                  listen;
  imu_bridge_pkg::byte_t tx_byte;
  logic                  tx_load;
  logic                  tx_done;

  imu_link_if link ();

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) i_rx (
    .clk     (clk),
    .reset   (reset),
    .i_rx    (i_uart_rx),
    .o_byte  (rx_byte),
    .o_valid (rx_valid)
  );

  command_accumulator i_accum (
    .clk       (clk),
    .reset     (reset),
    .i_byte    (rx_byte),
    .i_valid   (rx_valid),
    .i_listen  (listen),
    .i_expired (frame_expired),
    .o_word    (cmd_word),
    .o_first   (cmd_first),
    .o_done    (cmd_done),
    .o_error   (cmd_error)
  );

  frame_timer #(
    .FRAME_TIMEOUT(FRAME_TIMEOUT)
  ) i_timer (
    .clk       (clk),
    .reset     (reset),
    .i_arm     (cmd_first),
    .i_stop    (cmd_done | cmd_error),  // Frame closed either way
    .o_expired (frame_expired)
  );

  bridge_sequencer #(
    .OTP_PAD(OTP_PAD)
  ) i_seq (
    .clk        (clk),
    .reset      (reset),
    .i_word     (cmd_word),
    .i_cmd_done (cmd_done),
    .o_listen   (listen),
    .link       (link.host),
    .o_tx_byte  (tx_byte),
    .o_tx_load  (tx_load),
    .i_tx_done  (tx_done)
  );

  spi_imu_reader #(
    .CLKS_PER_HALF_SCLK(CLKS_PER_HALF_SCLK)
  ) i_spi (
    .clk        (clk),
    .reset      (reset),
    .link       (link.reader),
    .o_spi_sclk (o_spi_sclk),
    .o_spi_mosi (o_spi_mosi),
    .i_spi_miso (i_spi_miso),
    .o_spi_cs_n (o_spi_cs_n)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) i_tx (
    .clk    (clk),
    .reset  (reset),
    .i_byte (tx_byte),
    .i_load (tx_load),
    .o_tx   (o_uart_tx),
    .o_done (tx_done)
  );

endmodule

`default_nettype wire

//--- hdl/bridge_sequencer.sv
`default_nettype none

module bridge_sequencer #(
  parameter imu_bridge_pkg::word_t OTP_PAD = 16'hA5C3
) (
  input  wire                   clk,
  input  wire                   reset,
  input  imu_bridge_pkg::word_t i_word,
  input  wire                   i_cmd_done,
  output logic                  o_listen,
  imu_link_if.host              link,
  output imu_bridge_pkg::byte_t o_tx_byte,
  output logic                  o_tx_load,
  input  wire                   i_tx_done
);

  localparam logic [1:0] S_IDLE    = 2'd0;
  localparam logic [1:0] S_READ    = 2'd1;
  localparam logic [1:0] S_SEND    = 2'd2;
  localparam logic [1:0] S_WAIT_TX = 2'd3;

  logic [1:0]                state;
  logic                      enc_on;
  logic [1:0]                byte_idx;
  imu_bridge_pkg::word_t     pad_mask;
  imu_bridge_pkg::word_t     plain_cmd;
  imu_bridge_pkg::response_u rsp;
  logic [31:0]               cipher;

  assign pad_mask  = enc_on ? OTP_PAD : '0;
  assign plain_cmd = i_word ^ pad_mask;
  assign cipher    = rsp ^ {pad_mask, pad_mask};  // Each half padded on its own
  assign o_listen  = (state == S_IDLE);

  always_ff @(posedge clk) begin
    if (state == S_IDLE && i_cmd_done) begin
      link.command <= plain_cmd[2:0];
      if (plain_cmd == imu_bridge_pkg::CMD_ENC_OFF || plain_cmd == imu_bridge_pkg::CMD_ENC_ON) begin
        rsp.ack.status <= imu_bridge_pkg::STATUS_OK;
        rsp.ack.zero   <= '0;
        rsp.ack.id     <= {8'h00, imu_bridge_pkg::ENC_RSP_ID};
      end
    end else if (state == S_READ && link.done) begin
      rsp.yaw.status  <= imu_bridge_pkg::STATUS_OK;
      rsp.yaw.zero    <= '0;
      rsp.yaw.data_hi <= link.data[15:8];
      rsp.yaw.data_lo <= link.data[7:0];
      rsp.yaw.id      <= imu_bridge_pkg::YAW_RSP_ID;
    end
    if (state == S_SEND) begin
      o_tx_byte <= cipher[byte_idx*8 +: 8];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= S_IDLE;
      enc_on     <= 1'b0;
      byte_idx   <= '0;
      link.start <= 1'b0;
      o_tx_load  <= 1'b0;
    end else begin
      link.start <= 1'b0;
      o_tx_load  <= 1'b0;
      case (state)
        S_IDLE: begin
          byte_idx <= '0;
          if (i_cmd_done) begin
            if (plain_cmd == imu_bridge_pkg::CMD_ENC_OFF) begin
              enc_on <= 1'b0;
              state  <= S_SEND;  // Ack goes out in the new mode
            end else if (plain_cmd == imu_bridge_pkg::CMD_ENC_ON) begin
              enc_on <= 1'b1;
              state  <= S_SEND;
            end else begin
              link.start <= 1'b1;
              state      <= S_READ;
            end
          end
        end
        S_READ: begin
          if (link.done) begin
            state <= S_SEND;
          end
        end
        S_SEND: begin
          o_tx_load <= 1'b1;
          state     <= S_WAIT_TX;
        end
        default: begin
          if (i_tx_done) begin
            if (byte_idx == 2'(imu_bridge_pkg::RSP_BYTES - 1)) begin
              state <= S_IDLE;
            end else begin
              byte_idx <= byte_idx + 1'b1;
              state    <= S_SEND;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/spi_imu_reader.sv
`default_nettype none

module spi_imu_reader #(
  parameter int CLKS_PER_HALF_SCLK = 2
) (
  input  wire        clk,
  input  wire        reset,
  imu_link_if.reader link,
  output logic       o_spi_sclk,
  output logic       o_spi_mosi,
  input  wire        i_spi_miso,
  output logic       o_spi_cs_n
);

  localparam int CNT_W = (CLKS_PER_HALF_SCLK > 1) ? $clog2(CLKS_PER_HALF_SCLK) : 1;
  localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS_PER_HALF_SCLK - 1);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_SETUP = 2'd1;
  localparam logic [1:0] S_SHIFT = 2'd2;

  logic [1:0]       state;
  logic [CNT_W-1:0] clk_cnt;
  logic [5:0]       edge_cnt;  // 48 SCLK edges per transfer
  logic [7:0]       tx_shift;
  logic [15:0]      rx_shift;
  logic             half_done;

  assign o_spi_mosi = tx_shift[7];  // MSB first
  assign half_done  = (state == S_SHIFT) && (clk_cnt == HALF);

  // Sample on the rising edge, keeping the last two bytes
  always_ff @(posedge clk) begin
    if (half_done && !o_spi_sclk) begin
      rx_shift <= {rx_shift[14:0], i_spi_miso};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= S_IDLE;
      clk_cnt    <= '0;
      edge_cnt   <= '0;
      tx_shift   <= '0;
      o_spi_sclk <= 1'b0;
      o_spi_cs_n <= 1'b1;
      link.done  <= 1'b0;
    end else begin
      link.done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (link.start) begin
            state      <= S_SETUP;
            o_spi_cs_n <= 1'b0;
            tx_shift   <= {5'b0, link.command};  // Zero-extended command byte
          end
        end
        S_SETUP: begin
          state    <= S_SHIFT;
          clk_cnt  <= '0;
          edge_cnt <= '0;
        end
        default: begin
          if (half_done) begin
            clk_cnt    <= '0;
            edge_cnt   <= edge_cnt + 1'b1;
            o_spi_sclk <= !o_spi_sclk;
            if (o_spi_sclk) begin
              tx_shift <= {tx_shift[6:0], 1'b0};  // Next bit on the falling edge
            end
            if (edge_cnt == 6'd47) begin
              state      <= S_IDLE;
              o_spi_cs_n <= 1'b1;
              link.done  <= 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Low byte came first, so it sits in the upper half of the shifter
  always_ff @(posedge clk) begin
    if (half_done && edge_cnt == 6'd47) begin
      link.data <= {rx_shift[7:0], rx_shift[15:8]};
    end
  end

endmodule

`default_nettype wire

//--- hdl/frame_timer.sv
`default_nettype none

module frame_timer #(
  parameter int FRAME_TIMEOUT = 4000000
) (
  input  wire  clk,
  input  wire  reset,
  input  wire  i_arm,
  input  wire  i_stop,
  output logic o_expired
);

  localparam int CNT_W = $clog2(FRAME_TIMEOUT + 1);
  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(FRAME_TIMEOUT - 1);

  logic             running;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      running   <= 1'b0;
      count     <= '0;
      o_expired <= 1'b0;
    end else begin
      o_expired <= 1'b0;
      if (i_arm) begin
        running <= 1'b1;  // First byte of a new frame
        count   <= '0;
      end else if (i_stop) begin
        running <= 1'b0;
      end else if (running) begin
        if (count == LIMIT) begin
          running   <= 1'b0;
          o_expired <= 1'b1;  // Single pulse per frame
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/command_accumulator.sv
`default_nettype none

module command_accumulator (
  input  wire                   clk,
  input  wire                   reset,
  input  imu_bridge_pkg::byte_t i_byte,
  input  wire                   i_valid,
  input  wire                   i_listen,
  input  wire                   i_expired,
  output imu_bridge_pkg::word_t o_word,
  output logic                  o_first,
  output logic                  o_done,
  output logic                  o_error
);

  logic [1:0] count;  // Saturates at 3 to flag long frames
  logic       take;
  logic       is_term;

  assign take    = i_valid && i_listen;
  assign is_term = (i_byte == imu_bridge_pkg::FRAME_TERM);

  // Low byte first, then high byte
  always_ff @(posedge clk) begin
    if (take && !is_term && !i_expired) begin
      if (count == 2'd0) begin
        o_word[7:0] <= i_byte;
      end else if (count == 2'd1) begin
        o_word[15:8] <= i_byte;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count   <= '0;
      o_first <= 1'b0;
      o_done  <= 1'b0;
      o_error <= 1'b0;
    end else begin
      o_first <= 1'b0;
      o_done  <= 1'b0;
      o_error <= 1'b0;
      if (i_expired) begin
        count <= '0;  // Stale partial frame is dropped
      end else if (take) begin
        if (is_term) begin
          count   <= '0;
          o_done  <= (count == 2'd2);
          o_error <= (count != 2'd2);
        end else begin
          o_first <= (count == 2'd0);
          if (count != 2'd3) begin
            count <= count + 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 5208
) (
  input  wire                   clk,
  input  wire                   reset,
  input  imu_bridge_pkg::byte_t i_byte,
  input  wire                   i_load,
  output logic                  o_tx,
  output logic                  o_done
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS_PER_BIT - 1);

  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;  // 0 is the start bit, 9 the stop bit
  logic [8:0]       frame;    // Data bits then the stop bit

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      frame   <= '1;
      o_tx    <= 1'b1;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (!busy) begin
        if (i_load) begin
          busy    <= 1'b1;
          clk_cnt <= '0;
          bit_idx <= '0;
          frame   <= {1'b1, i_byte};
          o_tx    <= 1'b0;  // Start bit
        end
      end else if (clk_cnt == FULL) begin
        clk_cnt <= '0;
        if (bit_idx == 4'd9) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 1'b1;
          o_tx    <= frame[0];
          frame   <= {1'b1, frame[8:1]};
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 5208
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   i_rx,
  output imu_bridge_pkg::byte_t o_byte,
  output logic                  o_valid
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic [1:0]       state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic             rx_meta;
  logic             rx_sync;
  logic [7:0]       shift;

  assign o_byte = shift;  // Stable once o_valid strobes

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_DATA && clk_cnt == FULL) begin
      shift <= {rx_sync, shift[7:1]};  // LSB arrives first
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= S_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync) begin
            state <= S_START;
          end
        end
        S_START: begin
          if (clk_cnt == HALF) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? S_IDLE : S_DATA;  // Glitch goes back to idle
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (clk_cnt == FULL) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= S_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (clk_cnt == FULL) begin
            state   <= S_IDLE;
            o_valid <= rx_sync;  // Middle of the stop bit
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/imu_link_if.sv
`default_nettype none

interface imu_link_if;

  logic                     start;    // One-cycle request strobe
  imu_bridge_pkg::imu_cmd_t command;  // Valid with start
  logic                     done;     // One-cycle completion pulse
  imu_bridge_pkg::word_t    data;     // Valid with done

  modport host (
    output start,
    output command,
    input  done,
    input  data
  );

  modport reader (
    input  start,
    input  command,
    output done,
    output data
  );

endinterface

`default_nettype wire

//--- hdl/imu_bridge_pkg.sv
`default_nettype none

package imu_bridge_pkg;

  typedef logic [7:0]  byte_t;     // One UART or SPI byte
  typedef logic [15:0] word_t;     // Command or response half used as the cipher unit
  typedef logic [2:0]  imu_cmd_t;  // IMU command code

  localparam int RSP_BYTES = 4;    // Response length on the UART

  localparam word_t CMD_ENC_OFF = 16'd1;
  localparam word_t CMD_ENC_ON  = 16'd2;

  localparam byte_t ENC_RSP_ID = 8'd1;
  localparam byte_t YAW_RSP_ID = 8'd2;

  localparam byte_t FRAME_TERM = 8'h0D;  // Carriage return ends a frame
  localparam logic  STATUS_OK  = 1'b0;   // Bit 31 is low on success

  // Response word sent low byte first
  typedef union packed {
    struct packed {
      logic        status;
      logic [14:0] zero;
      word_t       id;
    } ack;
    struct packed {
      logic       status;
      logic [6:0] zero;
      byte_t      data_hi;
      byte_t      data_lo;
      byte_t      id;
    } yaw;
  } response_u;

endpackage

`default_nettype wire
